// ==== verilog/lc3_pkg.sv ====
package lc3_pkg;

    localparam int word_width = 16;

    typedef logic [word_width-1:0] word_t;
    typedef logic [2:0] reg_addr_t;

    // instruction bits 15:12
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ld   = 4'b0010,
        op_st   = 4'b0011,
        op_and  = 4'b0101,
        op_not  = 4'b1001,
        op_jmp  = 4'b1100,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } opcode_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_exec,
        st_mem_wait,
        st_halt
    } state_t;

    typedef enum logic [1:0] {
        res_alu,
        res_mem,
        res_addr,
        res_pc
    } result_sel_t;

    typedef enum logic [1:0] {alu_add, alu_and, alu_not} alu_op_t;

    typedef enum logic [1:0] {pc_increment, pc_address, pc_register} pc_sel_t;

endpackage

// ==== verilog/lc3_register_file.sv ====
module lc3_register_file (
    input  logic               clock,
    input  logic               reset,
    input  logic               write_enable,
    input  lc3_pkg::reg_addr_t write_addr,
    input  lc3_pkg::reg_addr_t read_addr_a,
    input  lc3_pkg::reg_addr_t read_addr_b,
    input  lc3_pkg::word_t     write_data,
    output lc3_pkg::word_t     read_data_a,
    output lc3_pkg::word_t     read_data_b
);

    lc3_pkg::word_t registers [8];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                registers[i] <= '0;
            end
        end else if (write_enable) begin
            registers[write_addr] <= write_data;
        end
    end

    // no bypass so a write shows up next cycle
    assign read_data_a = registers[read_addr_a];
    assign read_data_b = registers[read_addr_b];

endmodule

// ==== verilog/lc3_alu.sv ====
module lc3_alu (
    input  lc3_pkg::alu_op_t alu_op,
    input  lc3_pkg::word_t   operand_a,
    input  lc3_pkg::word_t   operand_b,
    input  lc3_pkg::word_t   pc,
    input  lc3_pkg::word_t   instruction,
    input  logic             use_immediate,
    output lc3_pkg::word_t   result,
    output lc3_pkg::word_t   address
);

    lc3_pkg::word_t imm5;
    lc3_pkg::word_t offset9;
    lc3_pkg::word_t operand_b_sel;

    assign imm5 = {{11{instruction[4]}}, instruction[4:0]};
    assign offset9 = {{7{instruction[8]}}, instruction[8:0]};
    assign operand_b_sel = use_immediate ? imm5 : operand_b;

    always_comb begin
        case (alu_op)
            lc3_pkg::alu_add: result = operand_a + operand_b_sel;
            lc3_pkg::alu_and: result = operand_a & operand_b_sel;
            lc3_pkg::alu_not: result = ~operand_a;
            default:          result = operand_a;
        endcase
    end

    // pc here is already the incremented one
    assign address = pc + offset9;

endmodule

// ==== verilog/lc3_memory_port.sv ====
module lc3_memory_port (
    input  logic           clock,
    input  logic           reset,
    input  logic           req_start,
    input  logic           req_write,
    input  logic           req_use_pc,
    input  lc3_pkg::word_t pc,
    input  lc3_pkg::word_t effective_address,
    input  lc3_pkg::word_t store_data,
    output logic           req_done,
    output lc3_pkg::word_t rsp_data,
    output logic           mem_valid,
    output logic           mem_write,
    output lc3_pkg::word_t mem_addr,
    output lc3_pkg::word_t mem_wdata,
    input  logic           mem_ready,
    input  logic           mem_rdata_valid,
    input  lc3_pkg::word_t mem_rdata
);

    logic read_pending;

    always_ff @(posedge clock) begin
        if (reset) begin
            mem_valid <= 1'b0;
            mem_write <= 1'b0;
            read_pending <= 1'b0;
            req_done <= 1'b0;
        end else begin
            req_done <= 1'b0;
            if (req_start) begin
                mem_valid <= 1'b1;
                mem_write <= req_write;
            end else if (mem_valid && mem_ready) begin
                mem_valid <= 1'b0;
                mem_write <= 1'b0;
                if (mem_write) begin
                    req_done <= 1'b1; // write done at transfer
                end else begin
                    read_pending <= 1'b1;
                end
            end
            if (read_pending && mem_rdata_valid) begin
                read_pending <= 1'b0;
                req_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (req_start) begin
            mem_addr <= req_use_pc ? pc : effective_address;
            mem_wdata <= store_data;
        end
        if (read_pending && mem_rdata_valid) begin
            rsp_data <= mem_rdata;
        end
    end

    stalled_request_stable: assert property (@(posedge clock) disable iff (reset)
        mem_valid && !mem_ready |=>
            mem_valid && $stable(mem_addr) && $stable(mem_write) && $stable(mem_wdata));

endmodule

// ==== verilog/lc3_datapath.sv ====
module lc3_datapath #(
    parameter lc3_pkg::word_t start_address = 16'h3000
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 load_ir,
    input  logic                 load_pc,
    input  logic                 load_reg,
    input  logic                 load_flags,
    input  lc3_pkg::pc_sel_t     pc_sel,
    input  lc3_pkg::result_sel_t result_sel,
    input  lc3_pkg::alu_op_t     alu_op,
    input  lc3_pkg::reg_addr_t   dest_reg,
    input  lc3_pkg::reg_addr_t   src_a_reg,
    input  lc3_pkg::reg_addr_t   src_b_reg,
    input  logic                 use_immediate,
    input  lc3_pkg::word_t       rsp_data,
    output lc3_pkg::word_t       instruction,
    output logic [2:0]           flags,
    output lc3_pkg::word_t       pc,
    output lc3_pkg::word_t       effective_address,
    output lc3_pkg::word_t       store_data
);

    lc3_pkg::word_t read_data_a;
    lc3_pkg::word_t read_data_b;
    lc3_pkg::word_t alu_result;
    lc3_pkg::word_t result;
    lc3_pkg::word_t pc_next;

    always_comb begin
        case (result_sel)
            lc3_pkg::res_mem:  result = rsp_data;
            lc3_pkg::res_addr: result = effective_address;
            default:           result = alu_result;
        endcase
    end

    always_comb begin
        case (pc_sel)
            lc3_pkg::pc_address:  pc_next = effective_address; // taken branch
            lc3_pkg::pc_register: pc_next = read_data_a;       // jmp
            default:              pc_next = pc + 16'd1;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= start_address;
            instruction <= '0;
            flags <= 3'b010;
        end else begin
            if (load_pc) begin
                pc <= pc_next;
            end
            if (load_ir) begin
                instruction <= rsp_data;
            end
            if (load_flags) begin
                flags <= {result[15], result == '0, !result[15] && result != '0};
            end
        end
    end

    assign store_data = read_data_a;

    lc3_register_file u_register_file (
        .clock        (clock),
        .reset        (reset),
        .write_enable (load_reg),
        .write_addr   (dest_reg),
        .read_addr_a  (src_a_reg),
        .read_addr_b  (src_b_reg),
        .write_data   (result),
        .read_data_a  (read_data_a),
        .read_data_b  (read_data_b)
    );

    lc3_alu u_alu (
        .alu_op        (alu_op),
        .operand_a     (read_data_a),
        .operand_b     (read_data_b),
        .pc            (pc),
        .instruction   (instruction),
        .use_immediate (use_immediate),
        .result        (alu_result),
        .address       (effective_address)
    );

endmodule

// ==== verilog/lc3_control.sv ====
module lc3_control (
    input  logic                 clock,
    input  logic                 reset,
    input  lc3_pkg::word_t       instruction,
    input  logic [2:0]           flags,
    input  logic                 req_done,
    output logic                 req_start,
    output logic                 req_write,
    output logic                 req_use_pc,
    output logic                 load_ir,
    output logic                 load_pc,
    output logic                 load_reg,
    output logic                 load_flags,
    output lc3_pkg::pc_sel_t     pc_sel,
    output lc3_pkg::result_sel_t result_sel,
    output lc3_pkg::alu_op_t     alu_op,
    output lc3_pkg::reg_addr_t   dest_reg,
    output lc3_pkg::reg_addr_t   src_a_reg,
    output lc3_pkg::reg_addr_t   src_b_reg,
    output logic                 use_immediate,
    output logic                 halted
);

    lc3_pkg::state_t  state;
    lc3_pkg::state_t  next_state;
    lc3_pkg::opcode_t opcode;
    logic             branch_taken;

    assign opcode = lc3_pkg::opcode_t'(instruction[15:12]);
    assign branch_taken = |(instruction[11:9] & flags); // any nzp bit matches

    assign dest_reg = instruction[11:9];
    assign src_a_reg = (opcode == lc3_pkg::op_st) ? instruction[11:9] : instruction[8:6];
    assign src_b_reg = instruction[2:0];
    assign use_immediate = instruction[5];
    assign halted = (state == lc3_pkg::st_halt);

    always_comb begin
        case (opcode)
            lc3_pkg::op_and: alu_op = lc3_pkg::alu_and;
            lc3_pkg::op_not: alu_op = lc3_pkg::alu_not;
            default:         alu_op = lc3_pkg::alu_add;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= lc3_pkg::st_fetch;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        req_start = 1'b0;
        req_write = 1'b0;
        req_use_pc = 1'b0;
        load_ir = 1'b0;
        load_pc = 1'b0;
        load_reg = 1'b0;
        load_flags = 1'b0;
        pc_sel = lc3_pkg::pc_increment;
        result_sel = lc3_pkg::res_alu;
        case (state)
            lc3_pkg::st_fetch: begin
                req_start = 1'b1;
                req_use_pc = 1'b1;
                next_state = lc3_pkg::st_fetch_wait;
            end
            lc3_pkg::st_fetch_wait: begin
                if (req_done) begin // ir and pc+1 on the same edge
                    load_ir = 1'b1;
                    load_pc = 1'b1;
                    next_state = lc3_pkg::st_decode;
                end
            end
            lc3_pkg::st_decode: begin
                case (opcode)
                    lc3_pkg::op_br, lc3_pkg::op_add, lc3_pkg::op_ld, lc3_pkg::op_st,
                    lc3_pkg::op_and, lc3_pkg::op_not, lc3_pkg::op_jmp, lc3_pkg::op_lea: begin
                        next_state = lc3_pkg::st_exec;
                    end
                    lc3_pkg::op_trap: next_state = lc3_pkg::st_halt;
                    default:          next_state = lc3_pkg::st_fetch; // no-op
                endcase
            end
            lc3_pkg::st_exec: begin
                next_state = lc3_pkg::st_fetch;
                case (opcode)
                    lc3_pkg::op_add, lc3_pkg::op_and, lc3_pkg::op_not: begin
                        load_reg = 1'b1;
                        load_flags = 1'b1;
                    end
                    lc3_pkg::op_lea: begin
                        load_reg = 1'b1; // flags untouched
                        result_sel = lc3_pkg::res_addr;
                    end
                    lc3_pkg::op_br: begin
                        load_pc = branch_taken;
                        pc_sel = lc3_pkg::pc_address;
                    end
                    lc3_pkg::op_jmp: begin
                        load_pc = 1'b1;
                        pc_sel = lc3_pkg::pc_register;
                    end
                    lc3_pkg::op_ld: begin
                        req_start = 1'b1;
                        next_state = lc3_pkg::st_mem_wait;
                    end
                    lc3_pkg::op_st: begin
                        req_start = 1'b1;
                        req_write = 1'b1;
                        next_state = lc3_pkg::st_mem_wait;
                    end
                    default: begin
                    end
                endcase
            end
            lc3_pkg::st_mem_wait: begin
                result_sel = lc3_pkg::res_mem;
                if (req_done) begin
                    load_reg = (opcode == lc3_pkg::op_ld);
                    load_flags = (opcode == lc3_pkg::op_ld);
                    next_state = lc3_pkg::st_fetch;
                end
            end
            lc3_pkg::st_halt: begin
            end
            default: next_state = lc3_pkg::st_fetch;
        endcase
    end

    // once halted the core stays quiet
    halt_is_final: assert property (@(posedge clock) disable iff (reset)
        state == lc3_pkg::st_halt |=> state == lc3_pkg::st_halt && !req_start);

    no_reg_and_pc_load: assert property (@(posedge clock) disable iff (reset)
        !(load_reg && load_pc));

endmodule

// ==== verilog/lc3_core.sv ====
module lc3_core #(
    parameter lc3_pkg::word_t start_address = 16'h3000
) (
    input  logic           clock,
    input  logic           reset,
    output logic           mem_valid,
    output logic           mem_write,
    output lc3_pkg::word_t mem_addr,
    output lc3_pkg::word_t mem_wdata,
    input  logic           mem_ready,
    input  logic           mem_rdata_valid,
    input  lc3_pkg::word_t mem_rdata,
    output logic           halted
);

    lc3_pkg::word_t       instruction;
    logic [2:0]           flags;
    logic                 req_start;
    logic                 req_write;
    logic                 req_use_pc;
    logic                 req_done;
    lc3_pkg::word_t       rsp_data;
    logic                 load_ir;
    logic                 load_pc;
    logic                 load_reg;
    logic                 load_flags;
    lc3_pkg::pc_sel_t     pc_sel;
    lc3_pkg::result_sel_t result_sel;
    lc3_pkg::alu_op_t     alu_op;
    lc3_pkg::reg_addr_t   dest_reg;
    lc3_pkg::reg_addr_t   src_a_reg;
    lc3_pkg::reg_addr_t   src_b_reg;
    logic                 use_immediate;
    lc3_pkg::word_t       pc;
    lc3_pkg::word_t       effective_address;
    lc3_pkg::word_t       store_data;

    lc3_control u_control (
        .clock         (clock),
        .reset         (reset),
        .instruction   (instruction),
        .flags         (flags),
        .req_done      (req_done),
        .req_start     (req_start),
        .req_write     (req_write),
        .req_use_pc    (req_use_pc),
        .load_ir       (load_ir),
        .load_pc       (load_pc),
        .load_reg      (load_reg),
        .load_flags    (load_flags),
        .pc_sel        (pc_sel),
        .result_sel    (result_sel),
        .alu_op        (alu_op),
        .dest_reg      (dest_reg),
        .src_a_reg     (src_a_reg),
        .src_b_reg     (src_b_reg),
        .use_immediate (use_immediate),
        .halted        (halted)
    );

    lc3_datapath #(
        .start_address (start_address)
    ) u_datapath (
        .clock             (clock),
        .reset             (reset),
        .load_ir           (load_ir),
        .load_pc           (load_pc),
        .load_reg          (load_reg),
        .load_flags        (load_flags),
        .pc_sel            (pc_sel),
        .result_sel        (result_sel),
        .alu_op            (alu_op),
        .dest_reg          (dest_reg),
        .src_a_reg         (src_a_reg),
        .src_b_reg         (src_b_reg),
        .use_immediate     (use_immediate),
        .rsp_data          (rsp_data),
        .instruction       (instruction),
        .flags             (flags),
        .pc                (pc),
        .effective_address (effective_address),
        .store_data        (store_data)
    );

    lc3_memory_port u_memory_port (
        .clock             (clock),
        .reset             (reset),
        .req_start         (req_start),
        .req_write         (req_write),
        .req_use_pc        (req_use_pc),
        .pc                (pc),
        .effective_address (effective_address),
        .store_data        (store_data),
        .req_done          (req_done),
        .rsp_data          (rsp_data),
        .mem_valid         (mem_valid),
        .mem_write         (mem_write),
        .mem_addr          (mem_addr),
        .mem_wdata         (mem_wdata),
        .mem_ready         (mem_ready),
        .mem_rdata_valid   (mem_rdata_valid),
        .mem_rdata         (mem_rdata)
    );

endmodule

// ==== bench/tb_lc3_core.sv ====
module tb_lc3_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int halt_timeout = 20000;

    logic        clock;
    logic        reset;
    logic        mem_valid;
    logic        mem_write;
    logic [15:0] mem_addr;
    logic [15:0] mem_wdata;
    logic        mem_ready;
    logic        mem_rdata_valid;
    logic [15:0] mem_rdata;
    logic        halted;

    logic [15:0] mem [0:65535];
    logic [15:0] expect_addr[$];
    logic [15:0] expect_data[$];
    logic [31:0] lfsr_state;

    logic        pending;
    int          rsp_delay;
    logic [15:0] rsp_word;
    logic        prev_stalled;
    logic        prev_write;
    logic [15:0] prev_addr;
    logic [15:0] prev_wdata;
    logic        first_seen;
    logic        halt_seen;
    int          transfers_after_halt;
    int          ready_bits;

    lc3_core #(
        .start_address (16'h3000)
    ) DUT (
        .clock           (clock),
        .reset           (reset),
        .mem_valid       (mem_valid),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_ready       (mem_ready),
        .mem_rdata_valid (mem_rdata_valid),
        .mem_rdata       (mem_rdata),
        .halted          (halted)
    );

    always #2 clock = ~clock;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            stop_with_failure("stopping at first error");
        end
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic load_testdata();
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  kind;
        logic [15:0] addr;
        logic [15:0] data;
        fd = $fopen("bench/lc3_testdata.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open bench/lc3_testdata.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0) begin
                fields = $sscanf(line, "%c %h %h", kind, addr, data);
                if (fields == 3 && kind == "m") begin
                    mem[addr] = data;
                end else if (fields == 3 && kind == "e") begin
                    expect_addr.push_back(addr);
                    expect_data.push_back(data);
                end
            end
        end
        $fclose(fd);
    endtask

    // memory model sampling at the falling edge where everything is settled
    always begin
        @(negedge clock);
        if (!reset) begin
            if (prev_stalled) begin
                check_value("stalled valid", 16'd1, {15'd0, mem_valid});
                check_value("stalled address", prev_addr, mem_addr);
                check_value("stalled write", {15'd0, prev_write}, {15'd0, mem_write});
                check_value("stalled write data", prev_wdata, mem_wdata);
            end
            if (halted === 1'b1) begin
                halt_seen = 1'b1;
            end
            if (mem_valid === 1'b1 && mem_ready) begin // transfers on the next edge
                if (!first_seen) begin
                    check_value("first request write", 16'd0, {15'd0, mem_write});
                    check_value("first request address", 16'h3000, mem_addr);
                    first_seen = 1'b1;
                end
                if (halt_seen) begin
                    transfers_after_halt++;
                end
                if (mem_write) begin
                    mem[mem_addr] = mem_wdata;
                end else begin
                    pending = 1'b1;
                    rsp_word = mem[mem_addr];
                    random_bits(2, rsp_delay); // 0 to 3 extra cycles
                end
            end
            prev_stalled = (mem_valid === 1'b1) && !mem_ready;
            prev_addr = mem_addr;
            prev_write = mem_write;
            prev_wdata = mem_wdata;
        end
        @(posedge clock);
        #1;
        mem_rdata_valid = 1'b0;
        if (pending) begin
            if (rsp_delay == 0) begin
                mem_rdata_valid = 1'b1;
                mem_rdata = rsp_word;
                pending = 1'b0;
            end else begin
                rsp_delay--;
            end
        end
        random_bits(2, ready_bits);
        mem_ready = (ready_bits != 0); // stall about one cycle in four
    end

    initial begin
        int cycles;
        clock = 1'b0;
        reset = 1'b1;
        mem_ready = 1'b0;
        mem_rdata_valid = 1'b0;
        mem_rdata = '0;
        lfsr_state = 32'h3277;
        pending = 1'b0;
        rsp_delay = 0;
        rsp_word = '0;
        prev_stalled = 1'b0;
        first_seen = 1'b0;
        halt_seen = 1'b0;
        transfers_after_halt = 0;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 16'(i) ^ 16'h5a5a;
        end
        load_testdata();

        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        check_value("halted after reset", 16'd0, {15'd0, halted});

        cycles = 0;
        while (halted !== 1'b1) begin
            @(posedge clock);
            #1;
            cycles++;
            if (cycles > halt_timeout) begin
                stop_with_failure("timeout waiting for the core to halt on trap");
            end
        end

        repeat (50) @(posedge clock);
        check_value("first request seen", 16'd1, {15'd0, first_seen});
        check_value("transfers after halt", 16'd0, 16'(transfers_after_halt));
        check_value("halted held", 16'd1, {15'd0, halted});

        foreach (expect_addr[i]) begin
            check_value($sformatf("mem[%h]", expect_addr[i]), expect_data[i],
                        mem[expect_addr[i]]);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/lc3_pkg.sv
verilog/lc3_register_file.sv
verilog/lc3_alu.sv
verilog/lc3_memory_port.sv
verilog/lc3_datapath.sv
verilog/lc3_control.sv
verilog/lc3_core.sv
bench/tb_lc3_core.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_lc3_core
FILELIST = tb.f
LOG      = sim.log

SOURCES  = $(wildcard verilog/*.sv) $(wildcard bench/*.sv)
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN) bench/lc3_testdata.txt
	./$(BIN) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/lc3_testdata.txt ====
// m <addr> <word> preloads memory, e <addr> <word> is expected after halt
// all values in hex
m 3000 223F
m 3001 1465
m 3002 1642
m 3003 58EF
m 3004 9AFF
m 3005 344A
m 3006 364A
m 3007 384A
m 3008 3A4A
m 3009 0401
m 300A 3849
m 300B 0801
m 300C 3848
m 300D 5DA0
m 300E 0A01
m 300F 3646
m 3010 0401
m 3011 3A45
m 3012 1DA1
m 3013 0201
m 3014 3A43
m 3015 0801
m 3016 3C42
m 3017 EE28
m 3018 3E41
m 3019 E002
m 301A C000
m 301B 323F
m 301C 323F
m 301D F025
m 3040 0123
m 3055 DEAD
m 3057 BEEF
m 3058 CAFE
m 305B 5555
e 3050 0128
e 3051 024B
e 3052 000B
e 3053 FDB4
e 3054 000B
e 3055 DEAD
e 3056 024B
e 3057 BEEF
e 3058 CAFE
e 3059 0001
e 305A 3040
e 305B 5555
e 305C 0123
